/* src.f */
+incdir+.
mem_msg_pkg.sv
mem_ctrl_pkg.sv
mem_req_if.sv
mem_resp_if.sv
mem_arbiter.sv
secure_mem.sv
mem_subsys_top.sv
mem_subsys_props.sv
mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the memory subsystem testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mem_subsys_tb -o mem_subsys_sim -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi
exit 0

/* mem_subsys_tb.sv */
`timescale 1ns/1ps
//----------------------------------------------------------
// Memory subsystem testbench
// Directed tests against a reference memory with protection
//----------------------------------------------------------
`include "mem_cfg.svh"

module mem_subsys_tb;
	import mem_msg_pkg::*;
	import mem_ctrl_pkg::*;

	localparam int NUM_TXNS        = 219;    // all tests together
	localparam int WATCHDOG_CYCLES = NUM_TXNS * 20 + 16;

	logic      clk;
	logic      reset;
	logic      req0_val;
	logic      req0_rdy;
	mem_type_t req0_type;
	opaque_t   req0_opaque;
	addr_t     req0_addr;
	data_t     req0_data;
	domain_t   req0_domain;
	logic      req1_val;
	logic      req1_rdy;
	mem_type_t req1_type;
	opaque_t   req1_opaque;
	addr_t     req1_addr;
	data_t     req1_data;
	domain_t   req1_domain;
	logic      resp0_val;
	logic      resp0_rdy;
	mem_type_t resp0_type;
	opaque_t   resp0_opaque;
	data_t     resp0_data;
	logic      resp0_insecure;
	domain_t   resp0_domain;
	logic      resp1_val;
	logic      resp1_rdy;
	mem_type_t resp1_type;
	opaque_t   resp1_opaque;
	data_t     resp1_data;
	logic      resp1_insecure;
	domain_t   resp1_domain;

	data_t       ref_mem [`MEM_DEPTH];
	logic        ref_valid [`MEM_DEPTH];    // word has been written
	int          cycle = 0;
	logic [31:0] rng_state = 32'd55628;

	mem_subsys_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	//----------------------------------------------------------
	// failure reporting and compare tasks
	//----------------------------------------------------------
	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "testbench stopped at the first failure");
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("** Error: %s data expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_opaque(input string name, input opaque_t exp, input opaque_t act);
		if (act !== exp) begin
			$display("** Error: %s opaque expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_type(input string name, input mem_type_t exp, input mem_type_t act);
		if (act !== exp) begin
			$display("** Error: %s type expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input domain_t exp, input domain_t act);
		if (act !== exp) begin
			$display("** Error: %s flag expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("** Error: %s cycles expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	//----------------------------------------------------------
	// reference model and bus tasks
	//----------------------------------------------------------
	task automatic apply_ref(input mem_type_t t, input addr_t a, input data_t d,
			input domain_t dom, output data_t exp_data, output logic exp_ins);
		logic blk;
		blk      = (dom == 1'b0) && a[`MEM_ADDR_NBITS-1];    // non-secure into upper half
		exp_ins  = blk;
		exp_data = '0;
		if (t == MEM_WRITE && !blk) begin
			ref_mem[a]   = d;
			ref_valid[a] = 1'b1;
		end else if (t == MEM_READ && !blk) begin
			exp_data = ref_mem[a];
		end
	endtask

	task automatic send_req(input logic port, input mem_type_t t, input opaque_t op,
			input addr_t a, input data_t d, input domain_t dom, output int acc_cycle);
		@(negedge clk);
		if (port == 1'b0) begin
			req0_val    = 1'b1;
			req0_type   = t;
			req0_opaque = op;
			req0_addr   = a;
			req0_data   = d;
			req0_domain = dom;
		end else begin
			req1_val    = 1'b1;
			req1_type   = t;
			req1_opaque = op;
			req1_addr   = a;
			req1_data   = d;
			req1_domain = dom;
		end
		#1;
		while (!(port == 1'b0 ? req0_rdy : req1_rdy)) begin
			@(negedge clk);
			#1;
		end
		acc_cycle = cycle;    // transfer happens at the coming rising edge
		@(negedge clk);
		if (port == 1'b0)
			req0_val = 1'b0;
		else
			req1_val = 1'b0;
	endtask

	task automatic recv_resp(input logic port, output mem_type_t t, output opaque_t op,
			output data_t d, output logic ins, output domain_t dom, output int cyc);
		do begin
			@(negedge clk);
			#1;
		end while (!(port == 1'b0 ? resp0_val : resp1_val));
		cyc = cycle;
		t   = (port == 1'b0) ? resp0_type : resp1_type;
		op  = (port == 1'b0) ? resp0_opaque : resp1_opaque;
		d   = (port == 1'b0) ? resp0_data : resp1_data;
		ins = (port == 1'b0) ? resp0_insecure : resp1_insecure;
		dom = (port == 1'b0) ? resp0_domain : resp1_domain;
	endtask

	task automatic do_txn(input string name, input logic port, input mem_type_t t,
			input opaque_t op, input addr_t a, input data_t d, input domain_t dom,
			output int acc, output int cyc);
		data_t     exp_data;
		logic      exp_ins;
		mem_type_t got_t;
		opaque_t   got_op;
		data_t     got_d;
		logic      got_ins;
		domain_t   got_dom;
		apply_ref(t, a, d, dom, exp_data, exp_ins);
		send_req(port, t, op, a, d, dom, acc);
		recv_resp(port, got_t, got_op, got_d, got_ins, got_dom, cyc);
		check_type(name, t, got_t);
		check_opaque(name, op, got_op);
		check_data(name, exp_data, got_d);
		check_flag(name, exp_ins, got_ins);
		check_flag(name, dom, got_dom);
	endtask

	//----------------------------------------------------------
	// tests
	//----------------------------------------------------------
	task automatic test_rw_ports();
		int acc;
		int cyc;
		do_txn("rw port 0", 1'b0, MEM_WRITE, 8'h01, 8'h10, 32'h1111_0010, 1'b0, acc, cyc);
		do_txn("rw port 0", 1'b0, MEM_READ, 8'h02, 8'h10, '0, 1'b0, acc, cyc);
		do_txn("rw port 1", 1'b1, MEM_WRITE, 8'h03, 8'h30, 32'h3333_0030, 1'b1, acc, cyc);
		do_txn("rw port 1", 1'b1, MEM_READ, 8'h04, 8'h30, '0, 1'b1, acc, cyc);
	endtask

	task automatic test_protection();
		int acc;
		int cyc;
		do_txn("protect", 1'b0, MEM_WRITE, 8'h11, 8'ha5, 32'h5ec0_00a5, 1'b1, acc, cyc);
		do_txn("protect", 1'b1, MEM_WRITE, 8'h12, 8'ha5, 32'hdead_beef, 1'b0, acc, cyc);
		do_txn("protect", 1'b0, MEM_READ, 8'h13, 8'ha5, '0, 1'b0, acc, cyc);
		do_txn("protect", 1'b1, MEM_READ, 8'h14, 8'ha5, '0, 1'b1, acc, cyc);
		// lower half is open to both domains
		do_txn("protect low", 1'b0, MEM_WRITE, 8'h15, 8'h25, 32'h0000_2525, 1'b0, acc, cyc);
		do_txn("protect low", 1'b1, MEM_READ, 8'h16, 8'h25, '0, 1'b1, acc, cyc);
		do_txn("protect low", 1'b1, MEM_WRITE, 8'h17, 8'h25, 32'h0001_2525, 1'b1, acc, cyc);
		do_txn("protect low", 1'b0, MEM_READ, 8'h18, 8'h25, '0, 1'b0, acc, cyc);
	endtask

	task automatic test_priority();
		int acc0;
		int cyc0;
		int acc1;
		int cyc1;
		fork
			do_txn("priority", 1'b0, MEM_WRITE, 8'h21, 8'h60, 32'h6060_6060, 1'b0, acc0, cyc0);
			do_txn("priority", 1'b1, MEM_READ, 8'h22, 8'h10, '0, 1'b0, acc1, cyc1);
		join
		if (acc1 <= cyc0 || cyc1 <= cyc0) begin
			$display("priority: port 1 was served before the port 0 response transferred");
			abort_run();
		end
	endtask

	task automatic test_backpressure();
		data_t exp_d;
		logic  exp_ins;
		data_t held;
		int    acc;
		int    cyc;
		do_txn("backpressure", 1'b0, MEM_WRITE, 8'h40, 8'h22, 32'hcafe_0022, 1'b0, acc, cyc);
		apply_ref(MEM_READ, 8'h22, '0, 1'b0, exp_d, exp_ins);
		@(negedge clk);
		resp0_rdy = 1'b0;
		send_req(1'b0, MEM_READ, 8'h41, 8'h22, '0, 1'b0, acc);
		do begin
			@(negedge clk);
			#1;
		end while (!resp0_val);
		check_data("backpressure read", exp_d, resp0_data);
		check_flag("backpressure read", exp_ins, resp0_insecure);
		held = resp0_data;
		fork
			do_txn("backpressure", 1'b1, MEM_WRITE, 8'h42, 8'h23, 32'h0bad_f00d, 1'b0, acc, cyc);
			begin
				repeat (10) begin
					@(negedge clk);
					#1;
					check_flag("backpressure resp0_val", 1'b1, resp0_val);
					check_data("backpressure hold", held, resp0_data);
					check_opaque("backpressure hold", 8'h41, resp0_opaque);
					check_flag("backpressure req1_rdy", 1'b0, req1_rdy);
				end
				@(negedge clk);
				resp0_rdy = 1'b1;
			end
		join
	endtask

	task automatic test_latency();
		int acc;
		int cyc;
		do_txn("latency", 1'b0, MEM_READ, 8'h50, 8'h22, '0, 1'b0, acc, cyc);
		check_count("latency port 0", `MEM_LATENCY + 2, cyc - acc);
		do_txn("latency", 1'b1, MEM_WRITE, 8'h51, 8'hc4, 32'h0c40_0c40, 1'b1, acc, cyc);
		check_count("latency port 1", `MEM_LATENCY + 2, cyc - acc);
	endtask

	task automatic test_random();
		logic [31:0] r;
		logic        port;
		mem_type_t   t;
		domain_t     dom;
		addr_t       a;
		opaque_t     op;
		data_t       d;
		int          acc;
		int          cyc;
		for (int i = 0; i < 200; i++) begin
			r    = lcg_next();
			port = r[31];
			t    = mem_type_t'(r[30]);
			dom  = r[29];
			a    = r[23:16];
			op   = r[15:8];
			d    = lcg_next();
			if (t == MEM_READ && !(dom == 1'b0 && a[`MEM_ADDR_NBITS-1]) && !ref_valid[a])
				t = MEM_WRITE;    // an unwritten word has no known contents
			do_txn("random", port, t, op, a, d, dom, acc, cyc);
		end
	endtask

	//----------------------------------------------------------
	// main sequence and watchdog
	//----------------------------------------------------------
	initial begin
		reset       = 1'b1;
		req0_val    = 1'b0;
		req0_type   = MEM_READ;
		req0_opaque = '0;
		req0_addr   = '0;
		req0_data   = '0;
		req0_domain = 1'b0;
		req1_val    = 1'b0;
		req1_type   = MEM_READ;
		req1_opaque = '0;
		req1_addr   = '0;
		req1_data   = '0;
		req1_domain = 1'b0;
		resp0_rdy   = 1'b1;
		resp1_rdy   = 1'b1;
		foreach (ref_valid[i])
			ref_valid[i] = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_rw_ports();
		test_protection();
		test_priority();
		test_backpressure();
		test_latency();
		test_random();
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

endmodule

/* mem_subsys_props.sv */
`timescale 1ns/1ps
//----------------------------------------------------------
// Handshake and reset properties of the memory subsystem
//----------------------------------------------------------
`include "mem_cfg.svh"

module mem_subsys_props (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    req0_rdy,
	input  logic                    req1_rdy,
	input  logic                    resp0_val,
	input  logic                    resp0_rdy,
	input  logic                    resp1_val,
	input  logic                    resp1_rdy,
	input  logic [`MEM_DATA_NBITS+`MEM_OPAQUE_NBITS+2:0] resp0_payload,
	input  logic [`MEM_DATA_NBITS+`MEM_OPAQUE_NBITS+2:0] resp1_payload,
	input  mem_ctrl_pkg::arb_state_t arb_state
);
	import mem_ctrl_pkg::*;

	a_req_rdy_excl: assert property (@(posedge clk) disable iff (reset)
		!(req0_rdy && req1_rdy)) else $error("both request ports ready at once");

	a_resp_val_excl: assert property (@(posedge clk) disable iff (reset)
		!(resp0_val && resp1_val)) else $error("both response ports valid at once");

	// a stalled response keeps its valid and payload
	a_resp0_hold: assert property (@(posedge clk) disable iff (reset)
		resp0_val && !resp0_rdy |=> resp0_val && $stable(resp0_payload))
		else $error("resp0 changed while stalled");

	a_resp1_hold: assert property (@(posedge clk) disable iff (reset)
		resp1_val && !resp1_rdy |=> resp1_val && $stable(resp1_payload))
		else $error("resp1 changed while stalled");

	a_reset_idle: assert property (@(posedge clk)
		reset |=> arb_state == ARB_IDLE && !req0_rdy && !req1_rdy && !resp0_val && !resp1_val)
		else $error("handshake outputs not idle after reset");
endmodule

bind mem_subsys_top mem_subsys_props props_i (
	.clk           (clk),
	.reset         (reset),
	.req0_rdy      (req0_rdy),
	.req1_rdy      (req1_rdy),
	.resp0_val     (resp0_val),
	.resp0_rdy     (resp0_rdy),
	.resp1_val     (resp1_val),
	.resp1_rdy     (resp1_rdy),
	.resp0_payload ({resp0_type, resp0_opaque, resp0_data, resp0_insecure, resp0_domain}),
	.resp1_payload ({resp1_type, resp1_opaque, resp1_data, resp1_insecure, resp1_domain}),
	.arb_state     (arb_i.state)
);

/* mem_subsys_top.sv */
`timescale 1ns/1ps
//----------------------------------------------------------
// Memory subsystem top level
// Two request ports through the arbiter into secure memory
//----------------------------------------------------------
module mem_subsys_top (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  req0_val,
	output logic                  req0_rdy,
	input  mem_msg_pkg::mem_type_t req0_type,
	input  mem_msg_pkg::opaque_t   req0_opaque,
	input  mem_msg_pkg::addr_t     req0_addr,
	input  mem_msg_pkg::data_t     req0_data,
	input  mem_ctrl_pkg::domain_t  req0_domain,

	input  logic                  req1_val,
	output logic                  req1_rdy,
	input  mem_msg_pkg::mem_type_t req1_type,
	input  mem_msg_pkg::opaque_t   req1_opaque,
	input  mem_msg_pkg::addr_t     req1_addr,
	input  mem_msg_pkg::data_t     req1_data,
	input  mem_ctrl_pkg::domain_t  req1_domain,

	output logic                  resp0_val,
	input  logic                  resp0_rdy,
	output mem_msg_pkg::mem_type_t resp0_type,
	output mem_msg_pkg::opaque_t   resp0_opaque,
	output mem_msg_pkg::data_t     resp0_data,
	output logic                  resp0_insecure,
	output mem_ctrl_pkg::domain_t  resp0_domain,

	output logic                  resp1_val,
	input  logic                  resp1_rdy,
	output mem_msg_pkg::mem_type_t resp1_type,
	output mem_msg_pkg::opaque_t   resp1_opaque,
	output mem_msg_pkg::data_t     resp1_data,
	output logic                  resp1_insecure,
	output mem_ctrl_pkg::domain_t  resp1_domain
);
	mem_req_if  req0 ();
	mem_req_if  req1 ();
	mem_resp_if resp0 ();
	mem_resp_if resp1 ();
	mem_req_if  mem_req ();     // arbiter to memory
	mem_resp_if mem_resp ();    // memory to arbiter

	//----------------------------------------------------------
	// core-side port mapping
	//----------------------------------------------------------
	assign req0.val      = req0_val;
	assign req0_rdy      = req0.rdy;
	assign req0.mem_type = req0_type;
	assign req0.opaque   = req0_opaque;
	assign req0.addr     = req0_addr;
	assign req0.data     = req0_data;
	assign req0.domain   = req0_domain;

	assign req1.val      = req1_val;
	assign req1_rdy      = req1.rdy;
	assign req1.mem_type = req1_type;
	assign req1.opaque   = req1_opaque;
	assign req1.addr     = req1_addr;
	assign req1.data     = req1_data;
	assign req1.domain   = req1_domain;

	assign resp0_val      = resp0.val;
	assign resp0.rdy      = resp0_rdy;
	assign resp0_type     = resp0.mem_type;
	assign resp0_opaque   = resp0.opaque;
	assign resp0_data     = resp0.data;
	assign resp0_insecure = resp0.insecure;
	assign resp0_domain   = resp0.domain;

	assign resp1_val      = resp1.val;
	assign resp1.rdy      = resp1_rdy;
	assign resp1_type     = resp1.mem_type;
	assign resp1_opaque   = resp1.opaque;
	assign resp1_data     = resp1.data;
	assign resp1_insecure = resp1.insecure;
	assign resp1_domain   = resp1.domain;

	mem_arbiter arb_i (
		.clk      (clk),
		.reset    (reset),
		.req0     (req0),
		.req1     (req1),
		.resp0    (resp0),
		.resp1    (resp1),
		.mem_req  (mem_req),
		.mem_resp (mem_resp)
	);

	secure_mem mem_i (
		.clk   (clk),
		.reset (reset),
		.req   (mem_req),
		.resp  (mem_resp)
	);

endmodule

/* secure_mem.sv */
`timescale 1ns/1ps
//----------------------------------------------------------
// Fixed-latency memory with a protected secure upper half
//----------------------------------------------------------
`include "mem_cfg.svh"

module secure_mem (
	input  logic        clk,
	input  logic        reset,
	mem_req_if.receiver req,
	mem_resp_if.sender  resp
);
	import mem_msg_pkg::*;
	import mem_ctrl_pkg::*;

	localparam int LAT_NBITS = $clog2(`MEM_LATENCY + 1);

	data_t                mem [`MEM_DEPTH];
	logic                 pending;
	logic [LAT_NBITS-1:0] lat_cnt;
	logic                 accept;
	logic                 blocked;

	mem_type_t            resp_type_q;
	opaque_t              resp_opaque_q;
	data_t                resp_data_q;
	logic                 resp_insecure_q;
	domain_t              resp_domain_q;

	assign req.rdy = !pending;    // only one request held at a time
	assign accept  = req.val && req.rdy;

	// non-secure access to the upper half
	assign blocked = (req.domain == 1'b0) && req.addr[`MEM_ADDR_NBITS-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			lat_cnt <= '0;
		end else if (accept) begin
			pending <= 1'b1;
			lat_cnt <= LAT_NBITS'(`MEM_LATENCY - 1);
		end else if (resp.val && resp.rdy) begin
			pending <= 1'b0;
		end else if (lat_cnt != '0) begin
			lat_cnt <= lat_cnt - 1'b1;
		end
	end

	// array access and response capture happen at acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			if (req.mem_type == MEM_WRITE && !blocked)
				mem[req.addr] <= req.data;
			if (req.mem_type == MEM_READ && !blocked)
				resp_data_q <= mem[req.addr];
			else
				resp_data_q <= '0;    // writes and blocked reads return zero
			resp_type_q     <= req.mem_type;
			resp_opaque_q   <= req.opaque;
			resp_insecure_q <= blocked;
			resp_domain_q   <= req.domain;
		end
	end

	assign resp.val      = pending && (lat_cnt == '0);
	assign resp.mem_type = resp_type_q;
	assign resp.opaque   = resp_opaque_q;
	assign resp.data     = resp_data_q;
	assign resp.insecure = resp_insecure_q;
	assign resp.domain   = resp_domain_q;

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps
//----------------------------------------------------------
// Two-port to one-port memory transaction arbiter
// Fixed priority to port 0, one transaction in flight
//----------------------------------------------------------
module mem_arbiter (
	input  logic         clk,
	input  logic         reset,
	mem_req_if.receiver  req0,
	mem_req_if.receiver  req1,
	mem_resp_if.sender   resp0,
	mem_resp_if.sender   resp1,
	mem_req_if.sender    mem_req,
	mem_resp_if.receiver mem_resp
);
	import mem_msg_pkg::*;
	import mem_ctrl_pkg::*;

	arb_state_t state;
	arb_state_t state_next;

	mem_type_t  req_type_q;
	opaque_t    req_opaque_q;
	addr_t      req_addr_q;
	data_t      req_data_q;
	domain_t    req_domain_q;

	mem_type_t  resp_type_q;
	opaque_t    resp_opaque_q;
	data_t      resp_data_q;
	logic       resp_insecure_q;
	domain_t    resp_domain_q;

	logic       req_en;
	logic       resp_en;

	//----------------------------------------------------------
	// state machine
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			state <= ARB_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			ARB_IDLE: begin
				if (req0.val)
					state_next = ARB_REQ0;    // port 0 wins a tie
				else if (req1.val)
					state_next = ARB_REQ1;
			end
			ARB_REQ0:  if (mem_req.rdy) state_next = ARB_WAIT0;
			ARB_REQ1:  if (mem_req.rdy) state_next = ARB_WAIT1;
			ARB_WAIT0: if (mem_resp.val) state_next = ARB_RESP0;
			ARB_WAIT1: if (mem_resp.val) state_next = ARB_RESP1;
			ARB_RESP0: if (resp0.rdy) state_next = ARB_IDLE;
			ARB_RESP1: if (resp1.rdy) state_next = ARB_IDLE;
			default:   state_next = ARB_IDLE;
		endcase
	end

	//----------------------------------------------------------
	// request side
	//----------------------------------------------------------
	assign req0.rdy = (state == ARB_IDLE) && req0.val;
	assign req1.rdy = (state == ARB_IDLE) && !req0.val && req1.val;
	assign req_en   = req0.rdy || req1.rdy;

	always_ff @(posedge clk) begin
		if (req_en) begin
			if (req0.rdy) begin
				req_type_q   <= req0.mem_type;
				req_opaque_q <= req0.opaque;
				req_addr_q   <= req0.addr;
				req_data_q   <= req0.data;
				req_domain_q <= req0.domain;
			end else begin
				req_type_q   <= req1.mem_type;
				req_opaque_q <= req1.opaque;
				req_addr_q   <= req1.addr;
				req_data_q   <= req1.data;
				req_domain_q <= req1.domain;
			end
		end
	end

	assign mem_req.val      = (state == ARB_REQ0) || (state == ARB_REQ1);
	assign mem_req.mem_type = req_type_q;
	assign mem_req.opaque   = req_opaque_q;
	assign mem_req.addr     = req_addr_q;
	assign mem_req.data     = req_data_q;
	assign mem_req.domain   = req_domain_q;

	//----------------------------------------------------------
	// response side
	//----------------------------------------------------------
	assign mem_resp.rdy = (state == ARB_WAIT0) || (state == ARB_WAIT1);
	assign resp_en      = mem_resp.rdy && mem_resp.val;

	always_ff @(posedge clk) begin
		if (resp_en) begin
			resp_type_q     <= mem_resp.mem_type;
			resp_opaque_q   <= mem_resp.opaque;
			resp_data_q     <= mem_resp.data;
			resp_insecure_q <= mem_resp.insecure;
			resp_domain_q   <= mem_resp.domain;
		end
	end

	// the state remembers which port issued the request
	assign resp0.val      = (state == ARB_RESP0);
	assign resp0.mem_type = resp_type_q;
	assign resp0.opaque   = resp_opaque_q;
	assign resp0.data     = resp_data_q;
	assign resp0.insecure = resp_insecure_q;
	assign resp0.domain   = resp_domain_q;

	assign resp1.val      = (state == ARB_RESP1);
	assign resp1.mem_type = resp_type_q;
	assign resp1.opaque   = resp_opaque_q;
	assign resp1.data     = resp_data_q;
	assign resp1.insecure = resp_insecure_q;
	assign resp1.domain   = resp_domain_q;

endmodule

/* mem_resp_if.sv */
`timescale 1ns/1ps
//----------------------------------------------------------
// Memory response channel with a valid/ready handshake
//----------------------------------------------------------
interface mem_resp_if;
	import mem_msg_pkg::*;
	import mem_ctrl_pkg::*;

	logic      val;
	logic      rdy;
	mem_type_t mem_type;
	opaque_t   opaque;
	data_t     data;
	logic      insecure;    // set when the access was blocked
	domain_t   domain;

	modport sender (
		output val, mem_type, opaque, data, insecure, domain,
		input  rdy
	);

	modport receiver (
		input  val, mem_type, opaque, data, insecure, domain,
		output rdy
	);
endinterface

/* mem_req_if.sv */
`timescale 1ns/1ps
//----------------------------------------------------------
// Memory request channel with a valid/ready handshake
//----------------------------------------------------------
interface mem_req_if;
	import mem_msg_pkg::*;
	import mem_ctrl_pkg::*;

	logic      val;
	logic      rdy;
	mem_type_t mem_type;
	opaque_t   opaque;
	addr_t     addr;
	data_t     data;
	domain_t   domain;    // domain of the issuing core

	modport sender (
		output val, mem_type, opaque, addr, data, domain,
		input  rdy
	);

	modport receiver (
		input  val, mem_type, opaque, addr, data, domain,
		output rdy
	);
endinterface

/* mem_ctrl_pkg.sv */
//----------------------------------------------------------
// Memory subsystem control types
//----------------------------------------------------------
package mem_ctrl_pkg;

	typedef logic [0:0] domain_t;    // 1 is secure, 0 is non-secure

	// the digit in each arbiter state names the port being served
	typedef enum logic [2:0] {
		ARB_IDLE, ARB_REQ0, ARB_REQ1, ARB_WAIT0, ARB_WAIT1, ARB_RESP0, ARB_RESP1
	} arb_state_t;

endpackage

/* mem_msg_pkg.sv */
//----------------------------------------------------------
// Memory message field types
// Shared by the request and response channels
//----------------------------------------------------------
`include "mem_cfg.svh"

package mem_msg_pkg;

	typedef logic [`MEM_ADDR_NBITS-1:0]   addr_t;
	typedef logic [`MEM_DATA_NBITS-1:0]   data_t;
	typedef logic [`MEM_OPAQUE_NBITS-1:0] opaque_t;    // returned untouched with the response

	// transaction type carried by both channels
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_type_t;

endpackage

/* mem_cfg.svh */
//----------------------------------------------------------
// Memory subsystem configuration
// Widths, memory depth and memory response latency
//----------------------------------------------------------
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// message field widths
`define MEM_ADDR_NBITS   8     // top bit selects the secure region
`define MEM_DATA_NBITS   32
`define MEM_OPAQUE_NBITS 8

// memory array
`define MEM_DEPTH        256   // one word per address
`define MEM_LATENCY      2     // cycles from acceptance to response valid

`endif
